/* spiPkg.sv */
// host-side SPI definitions, mode 0 only
// the flash count is fixed here and is not a module parameter
package spiPkg;

	// frame field widths
	localparam int opBits = 8;
	localparam int addrBits = 16;
	localparam int dataBits = 32;
	localparam int dummyBits = 8;

	// bit counter wide enough for the longest field
	localparam int bitCntBits = $clog2(dataBits);

	// flash devices behind the thru bridge
	localparam int sfmNum = 3;
	localparam int devSelBits = 2;

	// host pins, always moved as one bundle
	typedef struct packed {
		logic sck;
		logic mosi;
		logic csN;
	} spiPins_t;

	// bus idle levels
	localparam spiPins_t pinsIdle = '{sck: 1'b0, mosi: 1'b0, csN: 1'b1};

	// first byte of every frame
	// anything else sends the frame to skip
	typedef enum logic [opBits-1:0] {
		opWrite = 8'h02,
		opRead = 8'h03
	} spiOp_e;

	// decoder FSM
	typedef enum logic [2:0] {
		idle,
		opcode,
		address,
		writeData,
		apbAccess,
		dummy,
		readData,
		skip
	} decState_e;

endpackage

/* regPkg.sv */
// APB bundles and the register map of the small register file
// only word addresses listed here are mapped
package regPkg;

	// bus widths
	localparam int apbAddrBits = 16;
	localparam int apbDataBits = 32;

	// read/write control words, consecutive
	localparam int ctrlNum = 4;
	localparam logic [apbAddrBits-1:0] regCtrl0 = 16'h0000;
	localparam logic [apbAddrBits-1:0] regCtrl1 = 16'h0004;
	localparam logic [apbAddrBits-1:0] regCtrl2 = 16'h0008;
	localparam logic [apbAddrBits-1:0] regCtrl3 = 16'h000C;

	// read-only words
	localparam logic [apbAddrBits-1:0] regStatus = 16'h0010;
	localparam logic [apbAddrBits-1:0] regId = 16'h0014;

	// "SPI" plus revision 1
	localparam logic [apbDataBits-1:0] idValue = 32'h5350_4901;

	// what the host sees after a failed read
	localparam logic [apbDataBits-1:0] errData = 32'hFFFF_FFFF;

	// requester side
	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [apbAddrBits-1:0] paddr;
		logic [apbDataBits-1:0] pwdata;
	} apbReq_t;

	// completer side, pslverr only meaningful with pready
	typedef struct packed {
		logic [apbDataBits-1:0] prdata;
		logic pready;
		logic pslverr;
	} apbRsp_t;

endpackage

/* spiDecoder.sv */
// mode 0 frame decoder, SCK must stay at or below iSCLK/8
// one word per frame, read data has to land within the dummy byte
module spiDecoder
(
	input  logic iSCLK,
	input  logic rstN,
	input  logic enable,
	input  spiPkg::spiPins_t host,
	output logic miso,
	output regPkg::apbReq_t apbReq,
	input  regPkg::apbRsp_t apbRsp
);
	import spiPkg::*;
	import regPkg::*;

	spiPins_t pinsMeta;
	spiPins_t pins;
	logic sckPrev;
	logic csNPrev;
	logic sckRise;
	logic sckFall;
	logic csFall;
	decState_e state;
	logic [bitCntBits-1:0] bitCnt;
	logic lastBit;
	logic isRead;
	logic [dataBits-1:0] shiftIn;
	logic [dataBits-1:0] nextShift;
	logic [dataBits-1:0] rdShift;
	logic misoBit;
	logic psel;
	logic penable;
	logic pwrite;
	logic [addrBits-1:0] paddr;
	logic [dataBits-1:0] pwdata;
	logic apbStart;
	logic apbDone;

	// two flops on the raw pins, then one more for edge detect
	always_ff @(posedge iSCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			pinsMeta <= pinsIdle;
			pins <= pinsIdle;
			sckPrev <= 1'b0;
			csNPrev <= 1'b1;
		end
		else
		begin
			pinsMeta <= host;
			pins <= pinsMeta;
			sckPrev <= pins.sck;
			csNPrev <= pins.csN;
		end
	end

	assign sckRise = pins.sck && !sckPrev;
	assign sckFall = !pins.sck && sckPrev;
	assign csFall = !pins.csN && csNPrev;

	// msb first, sampled at sck rise
	assign nextShift = {shiftIn[dataBits-2:0], pins.mosi};

	// end of the current field
	always_comb
	begin
		case (state)
			opcode: lastBit = (bitCnt == bitCntBits'(opBits - 1));
			address: lastBit = (bitCnt == bitCntBits'(addrBits - 1));
			dummy: lastBit = (bitCnt == bitCntBits'(dummyBits - 1));
			default: lastBit = (bitCnt == bitCntBits'(dataBits - 1));
		endcase
	end

	// read starts after the address, write after the data word
	assign apbStart = enable && !pins.csN && sckRise && lastBit &&
		((state == address && isRead) || state == writeData);
	assign apbDone = psel && penable && apbRsp.pready;

	// frame FSM
	always_ff @(posedge iSCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= idle;
			bitCnt <= '0;
			isRead <= 1'b0;
		end
		else if (!enable || (state != idle && pins.csN))
		begin
			// thru mode or csN high drops the frame
			state <= idle;
			bitCnt <= '0;
		end
		else if (state == idle)
		begin
			if (csFall)
				state <= opcode;
		end
		else if (state == apbAccess)
		begin
			// write already shifted in, wait out the bus
			if (apbDone)
				state <= skip;
		end
		else if (sckRise && state != skip)
		begin
			bitCnt <= lastBit ? '0 : bitCnt + 1'b1;
			if (lastBit)
			begin
				case (state)
					opcode:
					begin
						case (spiOp_e'(nextShift[opBits-1:0]))
							opWrite:
							begin
								state <= address;
								isRead <= 1'b0;
							end
							opRead:
							begin
								state <= address;
								isRead <= 1'b1;
							end
							default: state <= skip;
						endcase
					end
					address: state <= isRead ? dummy : writeData;
					writeData: state <= apbAccess;
					dummy: state <= readData;
					// readData done, rest of frame ignored
					default: state <= skip;
				endcase
			end
		end
	end

	// input shifter
	always_ff @(posedge iSCLK)
	begin
		if (sckRise)
			shiftIn <= nextShift;
	end

	// APB handshake, runs on its own so an abort cannot cut it short
	always_ff @(posedge iSCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			psel <= 1'b0;
			penable <= 1'b0;
		end
		else if (apbStart)
		begin
			psel <= 1'b1;
			penable <= 1'b0;
		end
		else if (apbDone)
		begin
			psel <= 1'b0;
			penable <= 1'b0;
		end
		else if (psel)
			penable <= 1'b1;
	end

	// request payload, held until the next start
	always_ff @(posedge iSCLK)
	begin
		if (sckRise && state == address && lastBit)
			paddr <= nextShift[addrBits-1:0];
		if (apbStart)
		begin
			pwrite <= (state == writeData);
			pwdata <= nextShift;
		end
	end

	assign apbReq = '{
		psel: psel,
		penable: penable,
		pwrite: pwrite,
		paddr: paddr,
		pwdata: pwdata
	};

	// output shifter, errData replaces data on a slave error
	always_ff @(posedge iSCLK)
	begin
		if (apbDone && !pwrite)
			rdShift <= apbRsp.pslverr ? errData : apbRsp.prdata;
		else if (state == readData && sckFall)
			rdShift <= {rdShift[dataBits-2:0], 1'b0};
	end

	// first fall after the dummy byte puts out bit 31
	always_ff @(posedge iSCLK or negedge rstN)
	begin
		if (!rstN)
			misoBit <= 1'b0;
		else if (!enable || state != readData)
			misoBit <= 1'b0;
		else if (sckFall)
			misoBit <= rdShift[dataBits-1];
	end

	assign miso = misoBit;

endmodule

/* spiThruBridge.sv */
// host pins pass unsynchronised through one register stage
// devSel must be stable while csN is low, out of range selects nothing
module spiThruBridge
(
	input  logic iSCLK,
	input  logic rstN,
	input  logic active,
	input  logic [spiPkg::devSelBits-1:0] devSel,
	input  spiPkg::spiPins_t host,
	output logic [spiPkg::sfmNum-1:0] flashSck,
	output logic [spiPkg::sfmNum-1:0] flashMosi,
	output logic [spiPkg::sfmNum-1:0] flashCsN,
	input  logic [spiPkg::sfmNum-1:0] flashMiso,
	output logic miso
);
	import spiPkg::*;

	logic [sfmNum-1:0] devHit;
	logic misoReg;

	// one-hot device select, empty when bridge off
	always_comb
	begin
		for (int k = 0; k < sfmNum; k++)
		begin
			devHit[k] = active && (devSel == devSelBits'(k));
		end
	end

	// unselected devices parked with csN high and sck low
	always_ff @(posedge iSCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			flashSck <= '0;
			flashMosi <= '0;
			flashCsN <= '1;
			misoReg <= 1'b0;
		end
		else
		begin
			flashSck <= devHit & {sfmNum{host.sck}};
			flashMosi <= devHit & {sfmNum{host.mosi}};
			flashCsN <= ~devHit | {sfmNum{host.csN}};
			// return path from the chosen device only
			misoReg <= |(devHit & flashMiso);
		end
	end

	assign miso = misoReg;

endmodule

/* spiSlavePort.sv */
// thru and devSel may only change while the host holds csN high
// decoder and bridge never run at the same time
module spiSlavePort
(
	input  logic iSCLK,
	input  logic rstN,
	input  spiPkg::spiPins_t host,
	output logic miso,
	input  logic thru,
	input  logic [spiPkg::devSelBits-1:0] devSel,
	output regPkg::apbReq_t apbReq,
	input  regPkg::apbRsp_t apbRsp,
	output logic [spiPkg::sfmNum-1:0] flashSck,
	output logic [spiPkg::sfmNum-1:0] flashMosi,
	output logic [spiPkg::sfmNum-1:0] flashCsN,
	input  logic [spiPkg::sfmNum-1:0] flashMiso
);
	import spiPkg::*;

	logic thruMeta;
	logic thruSync;
	logic [devSelBits-1:0] devSelMeta;
	logic [devSelBits-1:0] devSelSync;
	logic decMiso;
	logic bridgeMiso;

	// mode controls come from slow pins, two flops each
	always_ff @(posedge iSCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			thruMeta <= 1'b0;
			thruSync <= 1'b0;
			devSelMeta <= '0;
			devSelSync <= '0;
		end
		else
		begin
			thruMeta <= thru;
			thruSync <= thruMeta;
			devSelMeta <= devSel;
			devSelSync <= devSelMeta;
		end
	end

	// register access when not in thru
	spiDecoder decoder
	(
		.iSCLK(iSCLK),
		.rstN(rstN),
		.enable(!thruSync),
		.host(host),
		.miso(decMiso),
		.apbReq(apbReq),
		.apbRsp(apbRsp)
	);

	// flash pass-through
	spiThruBridge bridge
	(
		.iSCLK(iSCLK),
		.rstN(rstN),
		.active(thruSync),
		.devSel(devSelSync),
		.host(host),
		.flashSck(flashSck),
		.flashMosi(flashMosi),
		.flashCsN(flashCsN),
		.flashMiso(flashMiso),
		.miso(bridgeMiso)
	);

	// host MISO follows the active block
	assign miso = thruSync ? bridgeMiso : decMiso;

endmodule

/* regFile.sv */
// APB completer, writes finish at once, reads take one wait state
// status and ID are read-only, a write to them is a slave error
module regFile
(
	input  logic iSCLK,
	input  logic rstN,
	input  regPkg::apbReq_t apbReq,
	output regPkg::apbRsp_t apbRsp,
	input  logic [regPkg::apbDataBits-1:0] status,
	output logic [regPkg::apbDataBits-1:0] ctrl0
);
	import regPkg::*;

	typedef enum logic {
		accFirst,
		accWait
	} accState_e;

	accState_e accState;
	logic [apbDataBits-1:0] ctrlReg [ctrlNum];
	logic [$clog2(ctrlNum)-1:0] ctrlIdx;
	logic [apbDataBits-1:0] rdMux;
	logic [apbDataBits-1:0] rdHold;
	logic isCtrl;
	logic addrErr;
	logic access;
	logic pready;

	assign access = apbReq.psel && apbReq.penable;

	// control words sit on consecutive word addresses
	assign ctrlIdx = apbReq.paddr[2 +: $clog2(ctrlNum)];

	// address decode
	always_comb
	begin
		rdMux = '0;
		isCtrl = 1'b0;
		addrErr = 1'b0;
		case (apbReq.paddr)
			regCtrl0, regCtrl1, regCtrl2, regCtrl3:
			begin
				isCtrl = 1'b1;
				rdMux = ctrlReg[ctrlIdx];
			end
			regStatus:
			begin
				rdMux = status;
				addrErr = apbReq.pwrite;
			end
			regId:
			begin
				rdMux = idValue;
				addrErr = apbReq.pwrite;
			end
			default: addrErr = 1'b1;
		endcase
	end

	// read wait state
	always_ff @(posedge iSCLK or negedge rstN)
	begin
		if (!rstN)
			accState <= accFirst;
		else if (access && !pready)
			accState <= accWait;
		else if (pready)
			accState <= accFirst;
	end

	// failed writes leave every register alone
	always_ff @(posedge iSCLK or negedge rstN)
	begin
		if (!rstN)
			ctrlReg <= '{default: '0};
		else if (access && apbReq.pwrite && isCtrl)
			ctrlReg[ctrlIdx] <= apbReq.pwdata;
	end

	// read data taken in the first access cycle
	always_ff @(posedge iSCLK)
	begin
		if (access && !apbReq.pwrite && accState == accFirst)
			rdHold <= rdMux;
	end

	assign pready = access && (apbReq.pwrite || accState == accWait);
	assign apbRsp = '{prdata: rdHold, pready: pready, pslverr: pready && addrErr};
	assign ctrl0 = ctrlReg[0];

endmodule

/* spiSubsys.sv */
// SPI slave port plus register file, mode 0 host, SCK up to iSCLK/8
// thru and devSel change only while host csN is high
module spiSubsys
(
	input  logic iSCLK,
	input  logic rstN,
	input  spiPkg::spiPins_t host,
	output logic miso,
	input  logic thru,
	input  logic [spiPkg::devSelBits-1:0] devSel,
	input  logic [regPkg::apbDataBits-1:0] status,
	output logic [regPkg::apbDataBits-1:0] ctrl0,
	output logic [spiPkg::sfmNum-1:0] flashSck,
	output logic [spiPkg::sfmNum-1:0] flashMosi,
	output logic [spiPkg::sfmNum-1:0] flashCsN,
	input  logic [spiPkg::sfmNum-1:0] flashMiso
);
	import regPkg::*;

	// internal register bus
	apbReq_t apbReq;
	apbRsp_t apbRsp;

	spiSlavePort port
	(
		.iSCLK(iSCLK),
		.rstN(rstN),
		.host(host),
		.miso(miso),
		.thru(thru),
		.devSel(devSel),
		.apbReq(apbReq),
		.apbRsp(apbRsp),
		.flashSck(flashSck),
		.flashMosi(flashMosi),
		.flashCsN(flashCsN),
		.flashMiso(flashMiso)
	);

	regFile regs
	(
		.iSCLK(iSCLK),
		.rstN(rstN),
		.apbReq(apbReq),
		.apbRsp(apbRsp),
		.status(status),
		.ctrl0(ctrl0)
	);

endmodule

/* spiSubsys_assertions.sv */
// bus rules on the internal APB link and the flash chip selects of spiSubsys
// reports through $error only, checks are off while rstN is low
module spiSubsys_assertions
(
	input  logic iSCLK,
	input  logic rstN,
	input  regPkg::apbReq_t apbReq,
	input  regPkg::apbRsp_t apbRsp,
	input  logic [spiPkg::sfmNum-1:0] flashCsN
);

	// access phase only inside a selected transfer
	penableNeedsPsel: assert property (@(posedge iSCLK) disable iff (!rstN)
		apbReq.penable |-> apbReq.psel)
		else $error("APB penable high without psel");

	// setup phase is followed by an unchanged access phase
	setupHolds: assert property (@(posedge iSCLK) disable iff (!rstN)
		apbReq.psel && !apbReq.penable |=>
		apbReq.psel && apbReq.penable && $stable(apbReq.paddr) &&
		$stable(apbReq.pwrite) && $stable(apbReq.pwdata))
		else $error("APB setup phase not followed by a stable access phase");

	// wait states keep the whole request
	waitHolds: assert property (@(posedge iSCLK) disable iff (!rstN)
		apbReq.penable && !apbRsp.pready |=> $stable(apbReq))
		else $error("APB request changed during a wait state");

	// slave error only with the completion
	errWithReady: assert property (@(posedge iSCLK) disable iff (!rstN)
		apbRsp.pslverr |-> apbRsp.pready)
		else $error("APB pslverr without pready");

	// never two flashes on the bus
	oneFlashCs: assert property (@(posedge iSCLK) disable iff (!rstN)
		$onehot0(~flashCsN))
		else $error("more than one flash chip select low");

endmodule

// every spiSubsys gets the checker on its internal bus and flash pins
bind spiSubsys spiSubsys_assertions checks
(
	.iSCLK(iSCLK),
	.rstN(rstN),
	.apbReq(apbReq),
	.apbRsp(apbRsp),
	.flashCsN(flashCsN)
);

/* tbSpiSubsys.sv */
// file-driven testbench, reads spi_input.txt from the project root
// host runs SPI mode 0 at iSCLK/8, flash models answer in thru mode only
module tbSpiSubsys;
	import spiPkg::*;
	import regPkg::*;

	localparam int lineNum = 28;
	localparam int resetCycles = 16;
	localparam int timeoutCycles = lineNum * 72 * 8 * 2 + resetCycles;
	// transaction kinds of the data file
	localparam logic [31:0] kindWrite = 0;
	localparam logic [31:0] kindRead = 1;
	localparam logic [31:0] kindAbort = 2;
	localparam logic [31:0] kindThru = 3;
	localparam logic [31:0] kindBadOp = 4;
	// fixed MISO pattern of each flash
	localparam logic [31:0] flashPat [sfmNum] = '{32'h9E3C_5A01, 32'h6B2D_7702, 32'hC48F_1E03};

	logic iSCLK;
	logic rstN;
	spiPins_t host;
	logic miso;
	logic thru;
	logic [devSelBits-1:0] devSel;
	logic [apbDataBits-1:0] status;
	logic [apbDataBits-1:0] ctrl0;
	logic [sfmNum-1:0] flashSck;
	logic [sfmNum-1:0] flashMosi;
	logic [sfmNum-1:0] flashCsN;
	logic [sfmNum-1:0] flashMiso;
	logic [31:0] stim [0:lineNum*4-1];
	logic [31:0] shadow [0:3];
	logic [31:0] thruMosi;
	logic [devSelBits-1:0] thruDev;
	logic thruOn;
	int flashRises [sfmNum];
	logic flashCsSeen [sfmNum];
	int cycleCnt = 0;

	initial iSCLK = 1'b0;
	always #10 iSCLK = ~iSCLK;

	spiSubsys DUT
	(
		.iSCLK(iSCLK),
		.rstN(rstN),
		.host(host),
		.miso(miso),
		.thru(thru),
		.devSel(devSel),
		.status(status),
		.ctrl0(ctrl0),
		.flashSck(flashSck),
		.flashMosi(flashMosi),
		.flashCsN(flashCsN),
		.flashMiso(flashMiso)
	);

	task automatic reportMismatch(input string name, input logic [31:0] expVal,
		input logic [31:0] actVal);
	begin
		$display("Fail at time %0t: %s expected %h actual %h", $time, name, expVal, actVal);
		$display("TESTBENCH FAILED");
		$fatal(1, "value mismatch");
	end
	endtask

	task automatic reportError(input string what);
	begin
		$display("Error at time %0t: %s", $time, what);
		$display("TESTBENCH FAILED");
		$fatal(1, "check failed");
	end
	endtask

	// n rising edges, then the drive offset
	task automatic driveSlot(input int n);
	begin
		repeat (n) @(posedge iSCLK);
		#2;
	end
	endtask

	// one mode 0 frame, msb first, abortBit cuts it short
	task automatic spiFrame(input logic [63:0] txBits, input int bitNum, input int abortBit,
		output logic [31:0] rxWord);
		logic [63:0] rxBits;
		int sendNum;
	begin
		rxBits = '0;
		sendNum = (abortBit != 0) ? abortBit : bitNum;
		driveSlot(1);
		host.csN = 1'b0;
		for (int i = 0; i < sendNum; i++)
		begin
			// MOSI moves with SCK low
			driveSlot(4);
			host.sck = 1'b0;
			host.mosi = txBits[bitNum-1-i];
			// MISO taken at the rise
			driveSlot(4);
			host.sck = 1'b1;
			rxBits = {rxBits[62:0], miso};
		end
		driveSlot(4);
		host.sck = 1'b0;
		driveSlot(4);
		host.csN = 1'b1;
		host.mosi = 1'b0;
		rxWord = rxBits[31:0];
	end
	endtask

	// expected register read after all writes so far
	function automatic logic [31:0] readModel(input logic [15:0] addr,
		input logic [31:0] statusVal);
		logic [31:0] value;
	begin
		if (addr[15:4] == 12'h000 && addr[1:0] == 2'b00)
			value = shadow[addr[3:2]];
		else if (addr == regStatus)
			value = statusVal;
		else if (addr == regId)
			value = idValue;
		else
			value = errData;
		return value;
	end
	endfunction

	// flash k answers with its own pattern and checks what the bridge forwards
	for (genvar k = 0; k < sfmNum; k++)
	begin : flashModel
		int bitIdx;

		// csN fall puts out the top bit
		always @(negedge flashCsN[k])
		begin
			assert (thruOn && thruDev == k)
			else
				reportError($sformatf("flash %0d selected while not addressed", k));
			flashCsSeen[k] = 1'b1;
			bitIdx = 31;
			#2;
			flashMiso[k] = flashPat[k][bitIdx];
		end

		always @(negedge flashSck[k])
		begin
			if (!flashCsN[k] && bitIdx > 0)
			begin
				bitIdx = bitIdx - 1;
				#2;
				flashMiso[k] = flashPat[k][bitIdx];
			end
		end

		// each rise must carry the host's next bit
		always @(posedge flashSck[k])
		begin
			assert (flashRises[k] < 32)
			else
				reportError($sformatf("flash %0d got more SCK edges than sent", k));
			assert (flashMosi[k] === thruMosi[31 - flashRises[k]])
			else
				reportMismatch($sformatf("flashMosi[%0d]", k), thruMosi[31 - flashRises[k]],
					flashMosi[k]);
			flashRises[k] = flashRises[k] + 1;
		end
	end

	// hang guard
	always @(posedge iSCLK)
	begin
		cycleCnt = cycleCnt + 1;
		if (cycleCnt >= timeoutCycles)
			reportError($sformatf("run did not finish within %0d cycles", timeoutCycles));
	end

	initial
	begin
		logic [31:0] kind;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] expVal;
		logic [31:0] rxWord;
		logic [31:0] model;
		int gap;

		void'($urandom(32'h5f7f));
		$readmemh("spi_input.txt", stim);
		rstN = 1'b0;
		host = pinsIdle;
		thru = 1'b0;
		devSel = '0;
		status = '0;
		flashMiso = '0;
		thruOn = 1'b0;
		thruDev = '0;
		thruMosi = '0;
		for (int i = 0; i < 4; i++)
			shadow[i] = '0;
		for (int i = 0; i < sfmNum; i++)
		begin
			flashRises[i] = 0;
			flashCsSeen[i] = 1'b0;
		end
		repeat (resetCycles) @(posedge iSCLK);
		#2;
		rstN = 1'b1;
		driveSlot(4);

		for (int line = 0; line < lineNum; line++)
		begin
			kind = stim[4*line];
			addr = stim[4*line+1];
			data = stim[4*line+2];
			expVal = stim[4*line+3];
			case (kind)
				kindWrite:
				begin
					spiFrame({8'h00, 8'h02, addr[15:0], data}, 56, 0, rxWord);
					// only the control words take writes
					if (addr[15:4] == 12'h000 && addr[1:0] == 2'b00)
						shadow[addr[3:2]] = data;
				end
				kindRead:
				begin
					status = data;
					spiFrame({8'h03, addr[15:0], 40'h0}, 64, 0, rxWord);
					model = readModel(addr[15:0], data);
					assert (expVal === model)
					else
						reportMismatch("shadow model", model, expVal);
					assert (rxWord === expVal)
					else
						reportMismatch("miso read data", expVal, rxWord);
				end
				kindAbort:
					spiFrame({8'h00, 8'h02, addr[15:0], data}, 56, int'(expVal), rxWord);
				kindBadOp:
					spiFrame({8'h00, addr[23:16], addr[15:0], data}, 56, 0, rxWord);
				kindThru:
				begin
					thruDev = addr[devSelBits-1:0];
					thruMosi = data;
					for (int i = 0; i < sfmNum; i++)
					begin
						flashRises[i] = 0;
						flashCsSeen[i] = 1'b0;
					end
					thruOn = 1'b1;
					thru = 1'b1;
					devSel = thruDev;
					// two-flop sync on the mode pins
					driveSlot(4);
					spiFrame({32'h0, data}, 32, 0, rxWord);
					assert (expVal === flashPat[thruDev])
					else
						reportMismatch("flash pattern", flashPat[thruDev], expVal);
					assert (rxWord === expVal)
					else
						reportMismatch("miso thru data", expVal, rxWord);
					assert (flashCsSeen[thruDev] && flashRises[thruDev] == 32)
					else
						reportError("selected flash did not see the whole frame");
					driveSlot(4);
					// host csN high releases every flash
					assert (flashCsN === {sfmNum{1'b1}})
					else
						reportMismatch("flashCsN", {sfmNum{1'b1}}, flashCsN);
					thru = 1'b0;
					driveSlot(4);
					thruOn = 1'b0;
				end
				default:
					reportError($sformatf("unknown kind %0h on data line %0d", kind, line));
			endcase
			gap = 4 + ($urandom % 13);
			driveSlot(gap);
			assert (ctrl0 === shadow[0])
			else
				reportMismatch("ctrl0", shadow[0], ctrl0);
		end

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

/* flist.f */
spiPkg.sv
regPkg.sv
spiDecoder.sv
spiThruBridge.sv
spiSlavePort.sv
regFile.sv
spiSubsys.sv
spiSubsys_assertions.sv
tbSpiSubsys.sv

/* Bender.yml */
package:
  name: spi_subsys

sources:
  # packages first, the rest depends on them
  - spiPkg.sv
  - regPkg.sv
  # design, leaf modules before the top
  - spiDecoder.sv
  - spiThruBridge.sv
  - spiSlavePort.sv
  - regFile.sv
  - spiSubsys.sv
  # verification
  - target: simulation
    files:
      - spiSubsys_assertions.sv
      - tbSpiSubsys.sv

/* spi_input.txt */
// columns: kind, address or device, data, expected (all hex)
// kind 0 write, 1 read (data drives status), 2 write cut after expected bits, 3 thru, 4 opcode in address bits 23:16
0 00000000 11223344 00000000
0 00000004 A5A55A5A 00000000
0 00000008 DEADBEEF 00000000
0 0000000C 0F0F0F0F 00000000
1 00000000 00000000 11223344
1 00000004 00000000 A5A55A5A
1 00000008 00000000 DEADBEEF
1 0000000C 00000000 0F0F0F0F
1 00000014 00000000 53504901
1 00000010 CAFEF00D CAFEF00D
1 00000010 00000001 00000001
1 00000020 00000000 FFFFFFFF
0 00000014 12345678 00000000
1 00000014 00000000 53504901
0 00000040 87654321 00000000
1 00000040 00000000 FFFFFFFF
0 00000000 76543210 00000000
2 00000004 FFFF0000 00000030
1 00000004 00000000 A5A55A5A
2 00000008 00000000 0000000C
1 00000008 00000000 DEADBEEF
4 00A5000C 00000000 00000000
1 0000000C 00000000 0F0F0F0F
3 00000000 3C3C0FF0 9E3C5A01
3 00000001 81F00F7E 6B2D7702
3 00000002 5AA5C33C C48F1E03
1 00000000 00000000 76543210
1 00000004 00000000 A5A55A5A
